//--- src/core_pkg.sv
package core_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  reg_idx_t;

    localparam int NUM_REGS = 8;

    // instruction fields.
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RD_MSB  = 11;
    localparam int RS1_MSB = 8;
    localparam int RS2_MSB = 5;
    localparam int IMM6_W  = 6;
    localparam int IMM9_W  = 9;

    localparam logic [3:0] OP_NOP  = 4'd0;
    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_SUB  = 4'd2;
    localparam logic [3:0] OP_ADDI = 4'd3;
    localparam logic [3:0] OP_LW   = 4'd4;
    localparam logic [3:0] OP_SW   = 4'd5;  // rd field is the store source.
    localparam logic [3:0] OP_BEQZ = 4'd6;
    localparam logic [3:0] OP_JMP  = 4'd7;

endpackage

//--- src/pipeline_ctrl.sv
`timescale 1ns/10ps

module pipeline_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic imem_ok_i,
    input  logic dmem_ok_i,
    input  logic mem_access_i,
    input  logic mem_is_load_i,
    input  logic id_jump_i,
    input  logic ex_branch_taken_i,
    input  logic ex_rs1_src_mem_i,
    input  logic ex_rs2_src_mem_i,
    input  logic ex_rs1_src_wb_i,
    input  logic ex_rs2_src_wb_i,
    output logic advance_o,
    output logic if_flush_o,
    output logic id_stall_o,
    output logic id_flush_o,
    output logic ex_stall_o,
    output logic ex_flush_o,
    output logic ex_rs1_buffered_o,
    output logic ex_rs2_buffered_o,
    output logic ex_rs1_use_buffer_o,
    output logic ex_rs2_use_buffer_o
);
    logic load_use;

    // whole pipeline freezes until both sides acknowledge.
    assign advance_o = imem_ok_i & (~mem_access_i | dmem_ok_i);

    assign load_use   = mem_is_load_i & (ex_rs1_src_mem_i | ex_rs2_src_mem_i);
    assign ex_stall_o = load_use;
    assign id_stall_o = load_use;
    assign ex_flush_o = load_use;  // bubble into mem.

    assign if_flush_o = ex_branch_taken_i | (id_jump_i & ~id_stall_o);
    assign id_flush_o = ex_branch_taken_i;

    // wb value leaves during the stall.
    assign ex_rs1_buffered_o = ex_rs1_src_wb_i & ex_stall_o;
    assign ex_rs2_buffered_o = ex_rs2_src_wb_i & ex_stall_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_rs1_use_buffer_o <= 1'b0;
            ex_rs2_use_buffer_o <= 1'b0;
        end else if (advance_o) begin
            ex_rs1_use_buffer_o <= ex_rs1_buffered_o;  // lasts one advance.
            ex_rs2_use_buffer_o <= ex_rs2_buffered_o;
        end
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance_i,
    input  logic            if_flush_i,
    input  logic            id_stall_i,
    input  logic            id_jump_i,
    input  core_pkg::addr_t jump_target_i,
    input  logic            branch_taken_i,
    input  core_pkg::addr_t branch_target_i,
    input  core_pkg::word_t imem_rdata_i,
    output core_pkg::addr_t imem_addr_o,
    output logic            id_valid_o,
    output core_pkg::word_t id_instr_o,
    output core_pkg::addr_t id_pc_o
);
    import core_pkg::*;

    addr_t pc;
    addr_t pc_next;
    logic  load;

    assign imem_addr_o = pc;
    assign load        = advance_i & ~id_stall_i;

    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else if (id_jump_i) begin
            pc_next = jump_target_i;
        end else begin
            pc_next = pc + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            id_valid_o <= 1'b0;
        end else if (load) begin
            pc         <= pc_next;
            id_valid_o <= ~if_flush_i;  // flushed slot becomes a bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            id_instr_o <= imem_rdata_i;
            id_pc_o    <= pc;
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               advance_i,
    input  logic               id_stall_i,
    input  logic               id_flush_i,
    input  logic               valid_i,
    input  core_pkg::word_t    instr_i,
    input  core_pkg::addr_t    pc_i,
    input  logic               wb_valid_i,
    input  core_pkg::reg_idx_t wb_rd_i,
    input  core_pkg::word_t    wb_data_i,
    output logic               jump_o,
    output core_pkg::addr_t    jump_target_o,
    output logic               ex_valid_o,
    output logic [3:0]         ex_op_o,
    output core_pkg::reg_idx_t ex_rd_o,
    output core_pkg::reg_idx_t ex_rs1_o,
    output core_pkg::reg_idx_t ex_rs2_o,
    output core_pkg::word_t    ex_a_o,
    output core_pkg::word_t    ex_b_o,
    output core_pkg::word_t    ex_imm_o,
    output core_pkg::addr_t    ex_pc_o
);
    import core_pkg::*;

    word_t            regs [NUM_REGS];
    logic [3:0]       op;
    reg_idx_t         rd;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    word_t            imm6;
    logic [IMM9_W-1:0] imm9;
    word_t            a;
    word_t            b;
    logic             load;

    assign op   = instr_i[OPC_MSB:OPC_LSB];
    assign rd   = instr_i[RD_MSB -: $bits(reg_idx_t)];
    assign imm6 = {{($bits(word_t) - IMM6_W){instr_i[IMM6_W-1]}}, instr_i[IMM6_W-1:0]};
    assign imm9 = instr_i[IMM9_W-1:0];

    // unused sources read r0 so they never match.
    assign rs1 = (op == OP_NOP || op == OP_JMP) ? '0 : instr_i[RS1_MSB -: $bits(reg_idx_t)];

    always_comb begin
        case (op)
            OP_ADD, OP_SUB: rs2 = instr_i[RS2_MSB -: $bits(reg_idx_t)];
            OP_SW:          rs2 = rd;
            default:        rs2 = '0;
        endcase
    end

    // r0 reads zero, same-cycle writeback passes through.
    assign a = (rs1 == '0) ? '0 :
               (wb_valid_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign b = (rs2 == '0) ? '0 :
               (wb_valid_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb_valid_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign jump_o        = valid_i & (op == OP_JMP);
    assign jump_target_o = pc_i + 8'd1 + addr_t'(imm9);  // wraps in 8 bits.

    assign load = advance_i & ~id_stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
        end else if (advance_i && id_flush_i) begin
            ex_valid_o <= 1'b0;
        end else if (load) begin
            ex_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_op_o  <= op;
            ex_rd_o  <= rd;
            ex_rs1_o <= rs1;
            ex_rs2_o <= rs2;
            ex_a_o   <= a;
            ex_b_o   <= b;
            ex_imm_o <= imm6;
            ex_pc_o  <= pc_i;
        end
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               advance_i,
    input  logic               ex_stall_i,
    input  logic               ex_flush_i,
    input  logic               rs1_buffered_i,
    input  logic               rs2_buffered_i,
    input  logic               rs1_use_buffer_i,
    input  logic               rs2_use_buffer_i,
    input  logic               valid_i,
    input  logic [3:0]         op_i,
    input  core_pkg::reg_idx_t rd_i,
    input  core_pkg::reg_idx_t rs1_i,
    input  core_pkg::reg_idx_t rs2_i,
    input  core_pkg::word_t    a_i,
    input  core_pkg::word_t    b_i,
    input  core_pkg::word_t    imm_i,
    input  core_pkg::addr_t    pc_i,
    input  core_pkg::reg_idx_t mem_rd_i,
    input  logic               mem_wr_i,
    input  core_pkg::word_t    mem_result_i,
    input  core_pkg::reg_idx_t wb_rd_i,
    input  logic               wb_valid_i,
    input  core_pkg::word_t    wb_data_i,
    output logic               rs1_src_mem_o,
    output logic               rs2_src_mem_o,
    output logic               rs1_src_wb_o,
    output logic               rs2_src_wb_o,
    output logic               branch_taken_o,
    output core_pkg::addr_t    branch_target_o,
    output logic               mem_valid_o,
    output logic [3:0]         mem_op_o,
    output core_pkg::reg_idx_t mem_rd_o,
    output core_pkg::word_t    mem_result_o,
    output core_pkg::word_t    mem_store_data_o
);
    import core_pkg::*;

    word_t rs1_buf;
    word_t rs2_buf;
    word_t op_a;
    word_t op_b;
    word_t result;

    assign rs1_src_mem_o = valid_i & mem_wr_i & (mem_rd_i == rs1_i);
    assign rs2_src_mem_o = valid_i & mem_wr_i & (mem_rd_i == rs2_i);

    // younger write in mem shadows wb.
    assign rs1_src_wb_o = valid_i & wb_valid_i & (wb_rd_i == rs1_i) & ~rs1_src_mem_o;
    assign rs2_src_wb_o = valid_i & wb_valid_i & (wb_rd_i == rs2_i) & ~rs2_src_mem_o;

    always_ff @(posedge clk) begin
        if (advance_i && rs1_buffered_i) begin
            rs1_buf <= wb_data_i;
        end
        if (advance_i && rs2_buffered_i) begin
            rs2_buf <= wb_data_i;
        end
    end

    always_comb begin
        if (rs1_use_buffer_i) begin
            op_a = rs1_buf;
        end else if (rs1_src_mem_o) begin
            op_a = mem_result_i;
        end else if (rs1_src_wb_o) begin
            op_a = wb_data_i;
        end else begin
            op_a = a_i;
        end
    end

    always_comb begin
        if (rs2_use_buffer_i) begin
            op_b = rs2_buf;
        end else if (rs2_src_mem_o) begin
            op_b = mem_result_i;
        end else if (rs2_src_wb_o) begin
            op_b = wb_data_i;
        end else begin
            op_b = b_i;
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            default: result = op_a + imm_i;  // addi and memory address.
        endcase
    end

    // operand is stale while stalled on a load.
    assign branch_taken_o  = valid_i & (op_i == OP_BEQZ) & (op_a == '0) & ~ex_stall_i;
    assign branch_target_o = pc_i + 8'd1 + addr_t'(imm_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
        end else if (advance_i) begin
            mem_valid_o <= valid_i & ~ex_flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            mem_op_o         <= op_i;
            mem_rd_o         <= rd_i;
            mem_result_o     <= result;
            mem_store_data_o <= op_b;
        end
    end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               advance_i,
    input  logic               valid_i,
    input  logic [3:0]         op_i,
    input  core_pkg::reg_idx_t rd_i,
    input  core_pkg::word_t    result_i,
    input  core_pkg::word_t    store_data_i,
    input  core_pkg::word_t    dmem_rdata_i,
    output logic               dmem_req_o,
    output logic               dmem_we_o,
    output core_pkg::addr_t    dmem_addr_o,
    output core_pkg::word_t    dmem_wdata_o,
    output logic               access_o,
    output logic               is_load_o,
    output logic               wr_o,
    output logic               wb_valid_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output core_pkg::word_t    wb_data_o
);
    import core_pkg::*;

    assign is_load_o = valid_i & (op_i == OP_LW);
    assign access_o  = valid_i & (op_i == OP_LW || op_i == OP_SW);

    // request held until acknowledged.
    assign dmem_req_o   = access_o;
    assign dmem_we_o    = valid_i & (op_i == OP_SW);
    assign dmem_addr_o  = addr_t'(result_i);
    assign dmem_wdata_o = store_data_i;

    // writes to r0 are dropped here.
    assign wr_o = valid_i & (rd_i != '0) & (op_i inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW});

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else if (advance_i) begin
            wb_valid_o <= wr_o;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= is_load_o ? dmem_rdata_i : result_i;  // load data valid on ack.
        end
    end

endmodule

//--- src/mini_core_top.sv
`timescale 1ns/10ps

module mini_core_top (
    input  logic               clk,
    input  logic               rst,
    output core_pkg::addr_t    imem_addr_o,
    input  core_pkg::word_t    imem_rdata_i,
    input  logic               imem_ok_i,
    output logic               dmem_req_o,
    output logic               dmem_we_o,
    output core_pkg::addr_t    dmem_addr_o,
    output core_pkg::word_t    dmem_wdata_o,
    input  core_pkg::word_t    dmem_rdata_i,
    input  logic               dmem_ok_i,
    output logic               wb_valid_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output core_pkg::word_t    wb_data_o
);
    import core_pkg::*;

    logic       advance;
    logic       if_flush;
    logic       id_stall;
    logic       id_flush;
    logic       ex_stall;
    logic       ex_flush;
    logic       rs1_buffered;
    logic       rs2_buffered;
    logic       rs1_use_buffer;
    logic       rs2_use_buffer;
    logic       id_jump;
    addr_t      jump_target;
    logic       branch_taken;
    addr_t      branch_target;
    logic       rs1_src_mem;
    logic       rs2_src_mem;
    logic       rs1_src_wb;
    logic       rs2_src_wb;
    logic       mem_access;
    logic       mem_is_load;
    logic       mem_wr;

    // IF/ID.
    logic       id_valid;
    word_t      id_instr;
    addr_t      id_pc;

    // ID/EX.
    logic       ex_valid;
    logic [3:0] ex_op;
    reg_idx_t   ex_rd;
    reg_idx_t   ex_rs1;
    reg_idx_t   ex_rs2;
    word_t      ex_a;
    word_t      ex_b;
    word_t      ex_imm;
    addr_t      ex_pc;

    // EX/MEM.
    logic       mem_valid;
    logic [3:0] mem_op;
    reg_idx_t   mem_rd;
    word_t      mem_result;
    word_t      mem_store_data;

    pipeline_ctrl u_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .imem_ok_i           (imem_ok_i),
        .dmem_ok_i           (dmem_ok_i),
        .mem_access_i        (mem_access),
        .mem_is_load_i       (mem_is_load),
        .id_jump_i           (id_jump),
        .ex_branch_taken_i   (branch_taken),
        .ex_rs1_src_mem_i    (rs1_src_mem),
        .ex_rs2_src_mem_i    (rs2_src_mem),
        .ex_rs1_src_wb_i     (rs1_src_wb),
        .ex_rs2_src_wb_i     (rs2_src_wb),
        .advance_o           (advance),
        .if_flush_o          (if_flush),
        .id_stall_o          (id_stall),
        .id_flush_o          (id_flush),
        .ex_stall_o          (ex_stall),
        .ex_flush_o          (ex_flush),
        .ex_rs1_buffered_o   (rs1_buffered),
        .ex_rs2_buffered_o   (rs2_buffered),
        .ex_rs1_use_buffer_o (rs1_use_buffer),
        .ex_rs2_use_buffer_o (rs2_use_buffer)
    );

    fetch_stage u_fetch (
        .clk             (clk),
        .rst             (rst),
        .advance_i       (advance),
        .if_flush_i      (if_flush),
        .id_stall_i      (id_stall),
        .id_jump_i       (id_jump),
        .jump_target_i   (jump_target),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .imem_rdata_i    (imem_rdata_i),
        .imem_addr_o     (imem_addr_o),
        .id_valid_o      (id_valid),
        .id_instr_o      (id_instr),
        .id_pc_o         (id_pc)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .advance_i     (advance),
        .id_stall_i    (id_stall),
        .id_flush_i    (id_flush),
        .valid_i       (id_valid),
        .instr_i       (id_instr),
        .pc_i          (id_pc),
        .wb_valid_i    (wb_valid_o),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .jump_o        (id_jump),
        .jump_target_o (jump_target),
        .ex_valid_o    (ex_valid),
        .ex_op_o       (ex_op),
        .ex_rd_o       (ex_rd),
        .ex_rs1_o      (ex_rs1),
        .ex_rs2_o      (ex_rs2),
        .ex_a_o        (ex_a),
        .ex_b_o        (ex_b),
        .ex_imm_o      (ex_imm),
        .ex_pc_o       (ex_pc)
    );

    execute_stage u_execute (
        .clk              (clk),
        .rst              (rst),
        .advance_i        (advance),
        .ex_stall_i       (ex_stall),
        .ex_flush_i       (ex_flush),
        .rs1_buffered_i   (rs1_buffered),
        .rs2_buffered_i   (rs2_buffered),
        .rs1_use_buffer_i (rs1_use_buffer),
        .rs2_use_buffer_i (rs2_use_buffer),
        .valid_i          (ex_valid),
        .op_i             (ex_op),
        .rd_i             (ex_rd),
        .rs1_i            (ex_rs1),
        .rs2_i            (ex_rs2),
        .a_i              (ex_a),
        .b_i              (ex_b),
        .imm_i            (ex_imm),
        .pc_i             (ex_pc),
        .mem_rd_i         (mem_rd),
        .mem_wr_i         (mem_wr),
        .mem_result_i     (mem_result),
        .wb_rd_i          (wb_rd_o),
        .wb_valid_i       (wb_valid_o),
        .wb_data_i        (wb_data_o),
        .rs1_src_mem_o    (rs1_src_mem),
        .rs2_src_mem_o    (rs2_src_mem),
        .rs1_src_wb_o     (rs1_src_wb),
        .rs2_src_wb_o     (rs2_src_wb),
        .branch_taken_o   (branch_taken),
        .branch_target_o  (branch_target),
        .mem_valid_o      (mem_valid),
        .mem_op_o         (mem_op),
        .mem_rd_o         (mem_rd),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data)
    );

    memory_stage u_memory (
        .clk          (clk),
        .rst          (rst),
        .advance_i    (advance),
        .valid_i      (mem_valid),
        .op_i         (mem_op),
        .rd_i         (mem_rd),
        .result_i     (mem_result),
        .store_data_i (mem_store_data),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .access_o     (mem_access),
        .is_load_o    (mem_is_load),
        .wr_o         (mem_wr),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o
);
    localparam realtime HALF_PERIOD = 10ns;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

endmodule

//--- testbench/mini_core_tb.sv
`timescale 1ns/10ps

module mini_core_tb;
    import core_pkg::*;

    logic     clk;
    logic     rst;
    addr_t    imem_addr_o;
    word_t    imem_rdata_i;
    logic     imem_ok_i;
    logic     dmem_req_o;
    logic     dmem_we_o;
    addr_t    dmem_addr_o;
    word_t    dmem_wdata_o;
    word_t    dmem_rdata_i;
    logic     dmem_ok_i;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    word_t    wb_data_o;

    word_t       imem [256];
    word_t       dmem [256];
    logic [31:0] rng_state = 32'h6b7b7f26;
    logic        prev_adv = 1'b1;  // wb register loaded in the last cycle.
    int          n_events;
    reg_idx_t    exp_rd [$];
    word_t       exp_wd [$];
    addr_t       exp_sa [$];
    word_t       exp_sd [$];

    tb_clock_gen u_clk (.clk_o(clk));

    mini_core_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .imem_ok_i    (imem_ok_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_ok_i    (dmem_ok_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    assign imem_rdata_i = imem[imem_addr_o];
    assign dmem_rdata_i = dmem[dmem_addr_o];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic word_t enc_r(logic [3:0] op, int rd, int rs1, int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
    endfunction

    function automatic word_t enc_i(logic [3:0] op, int rd, int rs1, int imm);
        return {op, 3'(rd), 3'(rs1), 6'(imm)};
    endfunction

    function automatic word_t enc_j(int imm);
        return {OP_JMP, 3'b000, 9'(imm)};
    endfunction

    // architectural model that stops at the jump to itself.
    function automatic void run_reference();
        word_t    r [8];
        word_t    m [256];
        addr_t    pc;
        word_t    ins;
        word_t    i6;
        addr_t    tgt;
        reg_idx_t rd;
        word_t    va;
        word_t    vb;
        for (int i = 0; i < 8; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) m[i] = '0;
        pc = '0;
        for (int step = 0; step < 500; step++) begin
            ins = imem[pc];
            rd  = ins[11:9];
            va  = r[ins[8:6]];
            vb  = r[ins[5:3]];
            i6  = {{10{ins[5]}}, ins[5:0]};
            tgt = pc + 8'd1 + addr_t'({{7{ins[8]}}, ins[8:0]});
            if (ins[15:12] == OP_JMP && tgt == pc) break;
            case (ins[15:12])
                OP_ADD:  r[rd] = va + vb;
                OP_SUB:  r[rd] = va - vb;
                OP_ADDI: r[rd] = va + i6;
                OP_LW:   r[rd] = m[addr_t'(va + i6)];
                OP_SW: begin
                    m[addr_t'(va + i6)] = r[rd];
                    exp_sa.push_back(addr_t'(va + i6));
                    exp_sd.push_back(r[rd]);
                end
                default: ;
            endcase
            if (ins[15:12] inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW} && rd != 0) begin
                exp_rd.push_back(rd);
                exp_wd.push_back(r[rd]);
            end
            r[0] = '0;
            if (ins[15:12] == OP_JMP) pc = tgt;
            else if (ins[15:12] == OP_BEQZ && va == '0) pc = pc + 8'd1 + addr_t'(i6);
            else pc = pc + 8'd1;
        end
    endfunction

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_error(string msg);
        $display("%s at %0t", msg, $time);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    initial begin
        rst       = 1'b1;
        imem_ok_i = 1'b0;
        dmem_ok_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        imem[0]  = enc_i(OP_ADDI, 1, 0, 5);
        imem[1]  = enc_i(OP_ADDI, 2, 0, 3);
        imem[2]  = enc_r(OP_ADD, 3, 1, 2);    // from mem and wb.
        imem[3]  = enc_r(OP_SUB, 4, 3, 1);
        imem[4]  = enc_r(OP_ADD, 5, 4, 3);
        imem[5]  = enc_i(OP_SW, 5, 0, 10);
        imem[6]  = enc_i(OP_ADDI, 6, 0, 7);
        imem[7]  = enc_i(OP_LW, 7, 0, 10);
        imem[8]  = enc_r(OP_ADD, 1, 7, 6);    // load-use with r6 through the buffer.
        imem[9]  = enc_i(OP_ADDI, 0, 1, 9);   // r0 stays zero.
        imem[10] = enc_r(OP_ADD, 2, 0, 1);
        imem[11] = enc_i(OP_BEQZ, 0, 0, 2);   // taken.
        imem[12] = enc_i(OP_ADDI, 3, 0, 1);
        imem[13] = enc_i(OP_ADDI, 3, 0, 2);
        imem[14] = enc_i(OP_BEQZ, 0, 1, 1);   // not taken.
        imem[15] = enc_i(OP_SW, 2, 1, -3);
        imem[16] = enc_j(1);
        imem[17] = enc_i(OP_ADDI, 4, 0, 9);
        imem[18] = enc_i(OP_LW, 3, 0, 15);
        imem[19] = enc_r(OP_SUB, 4, 3, 3);
        imem[20] = enc_j(-1);
        run_reference();
        n_events = exp_rd.size() + exp_sa.size();
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        check_value("imem_addr_o", word_t'(imem_addr_o), 16'h0000);
        check_value("dmem_req_o", word_t'(dmem_req_o), 16'h0000);
        check_value("wb_valid_o", word_t'(wb_valid_o), 16'h0000);
        while (exp_rd.size() != 0 || exp_sa.size() != 0) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk);  // catch stray retirements.
        $display("Test passed");
        $finish;
    end

    // random wait states on both memories.
    always @(posedge clk) begin
        #2;
        rng_state = xorshift32(rng_state);
        imem_ok_i = (rng_state[2:0] != 3'd0);
        dmem_ok_i = (rng_state[6:4] != 3'd0);
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (prev_adv && wb_valid_o) begin
                if (exp_rd.size() == 0) begin
                    report_error("register write retired beyond the expected list");
                end else begin
                    check_value("wb_rd_o", word_t'(wb_rd_o), word_t'(exp_rd.pop_front()));
                    check_value("wb_data_o", wb_data_o, exp_wd.pop_front());
                end
            end
            // store completes when the pipeline moves on.
            if (dmem_req_o && dmem_we_o && dmem_ok_i && imem_ok_i) begin
                if (exp_sa.size() == 0) begin
                    report_error("store issued beyond the expected list");
                end else begin
                    check_value("dmem_addr_o", word_t'(dmem_addr_o),
                                word_t'(exp_sa.pop_front()));
                    check_value("dmem_wdata_o", dmem_wdata_o, exp_sd.pop_front());
                    dmem[dmem_addr_o] <= dmem_wdata_o;
                end
            end
            prev_adv <= imem_ok_i && (!dmem_req_o || dmem_ok_i);
        end
    end

    initial begin
        #1;
        #((n_events * 40 + 16 + 30) * 20);
        report_error("watchdog expired before all expected events were seen");
    end

endmodule

//--- mini_core_top.f
src/core_pkg.sv
src/pipeline_ctrl.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mini_core_top.sv
testbench/tb_clock_gen.sv
testbench/mini_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
    -f mini_core_top.f \
    --top-module mini_core_tb \
    -o sim_mini_core

./obj_dir/sim_mini_core
